// ==== files.f ====
+incdir+src
src/dcache_pkg.sv
src/dcache_way.sv
src/dcache_control.sv
src/dcache_write_buffer.sv
src/dcache_top.sv
verification/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module dcache_tb -f files.f -o dcache_sim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/dcache_sim > sim.log 2>&1 ; cat sim.log
grep -qx "TEST PASS" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== src/dcache_cfg.svh ====
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Two ways only, since each set keeps a single LRU bit
`define DCACHE_WAYS 2

// 64 sets of 4-word lines, 2 KiB in total
`define DCACHE_INDEX_BITS 6
`define DCACHE_OFFSET_BITS 2

// Physical word address from the processor
`define DCACHE_ADDR_BITS 30

// Dirty victim lines waiting for memory
`define DCACHE_WB_DEPTH 4

`endif

// ==== src/dcache_control.sv ====
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_control (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [`DCACHE_ADDR_BITS-1:0]  address,
    input  logic                          read,
    input  dcache_pkg::byte_en_t          write_en,
    input  dcache_pkg::word_t             write_data,
    output dcache_pkg::word_t             read_data,
    output logic                          ready,
    input  logic                          mem_ready,
    input  dcache_pkg::word_t             mem_read_data,
    input  dcache_pkg::offset_t           mem_read_offset,
    output logic                          mem_read_line,
    output dcache_pkg::line_addr_t        fill_address,
    input  dcache_pkg::way_sel_t          way_hit,
    input  dcache_pkg::way_sel_t          way_valid,
    input  dcache_pkg::way_sel_t          way_dirty,
    input  dcache_pkg::word_t             way_word [`DCACHE_WAYS],
    output dcache_pkg::index_t            index,
    output dcache_pkg::offset_t           offset,
    output dcache_pkg::tag_t              tag,
    output dcache_pkg::word_t             write_data_q,
    output dcache_pkg::byte_en_t          write_en_q,
    output dcache_pkg::word_t             fill_data,
    output dcache_pkg::offset_t           fill_offset,
    output dcache_pkg::way_sel_t          way_write,
    output dcache_pkg::way_sel_t          way_fill,
    output dcache_pkg::way_sel_t          way_validate,
    input  logic                          wb_full,
    input  logic                          wb_empty,
    output logic                          wb_enqueue,
    output logic                          victim_way
);

    import dcache_pkg::*;

    localparam logic [2:0] IDLE        = 3'd0;
    localparam logic [2:0] TAG_CHECK   = 3'd1;
    localparam logic [2:0] WRITEBACK   = 3'd2;
    localparam logic [2:0] FILL        = 3'd3;
    localparam logic [2:0] FILL_WAIT_1 = 3'd4;
    localparam logic [2:0] FILL_WAIT_2 = 3'd5;
    localparam logic [2:0] FILL_WAIT_3 = 3'd6;
    localparam logic [2:0] FILL_WAIT_4 = 3'd7;

    localparam int SETS = 1 << `DCACHE_INDEX_BITS;

    logic [2:0]                  state;
    logic [2:0]                  state_next;
    logic [`DCACHE_ADDR_BITS-1:0] address_q;
    logic [SETS-1:0]             lru_bits; // Names the least recently used way
    logic                        capture;
    logic                        hit_any;
    logic                        victim_new;
    logic                        victim_dirty;
    logic                        fill_word;
    way_sel_t                    victim_sel;

    assign capture = (state == IDLE) & (read | (write_en != '0));

    // Request registers
    always_ff @(posedge clock) begin
        if (capture) begin
            address_q    <= address;
            write_en_q   <= write_en;
            write_data_q <= write_data;
        end
    end

    assign offset       = address_q[`DCACHE_OFFSET_BITS-1:0];
    assign index        = address_q[`DCACHE_OFFSET_BITS +: `DCACHE_INDEX_BITS];
    assign tag          = address_q[`DCACHE_ADDR_BITS-1:`DCACHE_OFFSET_BITS+`DCACHE_INDEX_BITS];
    assign fill_address = {tag, index};

    assign hit_any = |way_hit;

    // Victim is an empty way first, then the LRU way
    always_comb begin
        if (!way_valid[0]) begin
            victim_new = 1'b0;
        end else if (!way_valid[1]) begin
            victim_new = 1'b1;
        end else begin
            victim_new = lru_bits[index];
        end
    end

    assign victim_dirty = way_valid[victim_new] & way_dirty[victim_new];

    // Held from the missing tag check until the refill validates
    always_ff @(posedge clock) begin
        if (reset) begin
            victim_way <= 1'b0;
        end else if ((state == TAG_CHECK) && !hit_any) begin
            victim_way <= victim_new;
        end
    end

    assign victim_sel = way_sel_t'(1) << victim_way;

    always_ff @(posedge clock) begin
        if (reset) begin
            lru_bits <= '0;
        end else if (ready) begin
            lru_bits[index] <= ~way_hit[1]; // Point at the way not just used
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:        state_next = capture ? TAG_CHECK : IDLE;
            TAG_CHECK: begin
                if (hit_any) begin
                    state_next = IDLE;
                end else if (victim_dirty) begin
                    state_next = WRITEBACK;
                end else begin
                    state_next = FILL;
                end
            end
            WRITEBACK:   state_next = wb_full ? WRITEBACK : FILL;
            FILL:        state_next = wb_empty ? FILL_WAIT_1 : FILL;
            FILL_WAIT_1: state_next = mem_ready ? FILL_WAIT_2 : FILL_WAIT_1;
            FILL_WAIT_2: state_next = mem_ready ? FILL_WAIT_3 : FILL_WAIT_2;
            FILL_WAIT_3: state_next = mem_ready ? FILL_WAIT_4 : FILL_WAIT_3;
            FILL_WAIT_4: state_next = mem_ready ? TAG_CHECK : FILL_WAIT_4;
            default:     state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign ready         = (state == TAG_CHECK) & hit_any;
    assign wb_enqueue    = (state == WRITEBACK) & ~wb_full;
    assign mem_read_line = (state == FILL) & wb_empty; // Fill waits for a drained buffer

    // Fill words go straight into the victim way
    assign fill_word    = mem_ready & ((state == FILL_WAIT_1) | (state == FILL_WAIT_2) |
                                       (state == FILL_WAIT_3) | (state == FILL_WAIT_4));
    assign fill_data    = mem_read_data;
    assign fill_offset  = mem_read_offset;
    assign way_fill     = fill_word ? victim_sel : '0;
    assign way_validate = ((state == FILL_WAIT_4) && mem_ready) ? victim_sel : '0;
    assign way_write    = ((state == TAG_CHECK) && (write_en_q != '0)) ? way_hit : '0;

    // Hit word select
    always_comb begin
        read_data = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (way_hit[w]) begin
                read_data = way_word[w];
            end
        end
    end

endmodule

// ==== src/dcache_pkg.sv ====
`include "dcache_cfg.svh"

package dcache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [127:0] line_t; // Word 0 in the low bits
    typedef logic [3:0] byte_en_t;

    typedef logic [`DCACHE_INDEX_BITS-1:0] index_t;
    typedef logic [`DCACHE_OFFSET_BITS-1:0] offset_t;

    // Address bits above index and offset
    typedef logic [`DCACHE_ADDR_BITS-`DCACHE_INDEX_BITS-`DCACHE_OFFSET_BITS-1:0] tag_t;

    // Tag and index, as memory sees a line
    typedef logic [`DCACHE_ADDR_BITS-`DCACHE_OFFSET_BITS-1:0] line_addr_t;

    // One bit per way
    typedef logic [`DCACHE_WAYS-1:0] way_sel_t;

endpackage

// ==== src/dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_top (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [`DCACHE_ADDR_BITS-1:0] address,
    input  logic                         read,
    input  dcache_pkg::byte_en_t         write_en,
    input  dcache_pkg::word_t            write_data,
    output dcache_pkg::word_t            read_data,
    output logic                         ready,
    output dcache_pkg::line_addr_t       mem_address,
    output logic                         mem_read_line,
    input  dcache_pkg::word_t            mem_read_data,
    input  dcache_pkg::offset_t          mem_read_offset,
    input  logic                         mem_ready,
    output dcache_pkg::line_t            mem_line_out,
    output logic                         mem_line_out_valid
);

    import dcache_pkg::*;

    index_t     index;
    offset_t    offset;
    tag_t       tag;
    word_t      write_data_q;
    byte_en_t   write_en_q;
    word_t      fill_data;
    offset_t    fill_offset;
    line_addr_t fill_address;
    way_sel_t   way_write, way_fill, way_validate;
    way_sel_t   way_hit, way_valid, way_dirty;
    word_t      way_word [`DCACHE_WAYS];
    tag_t       way_tag [`DCACHE_WAYS];
    line_t      way_line [`DCACHE_WAYS];
    logic       wb_full, wb_empty, wb_enqueue, victim_way;

    dcache_control i_dcache_control (
        .clock           (clock),
        .reset           (reset),
        .address         (address),
        .read            (read),
        .write_en        (write_en),
        .write_data      (write_data),
        .read_data       (read_data),
        .ready           (ready),
        .mem_ready       (mem_ready),
        .mem_read_data   (mem_read_data),
        .mem_read_offset (mem_read_offset),
        .mem_read_line   (mem_read_line),
        .fill_address    (fill_address),
        .way_hit         (way_hit),
        .way_valid       (way_valid),
        .way_dirty       (way_dirty),
        .way_word        (way_word),
        .index           (index),
        .offset          (offset),
        .tag             (tag),
        .write_data_q    (write_data_q),
        .write_en_q      (write_en_q),
        .fill_data       (fill_data),
        .fill_offset     (fill_offset),
        .way_write       (way_write),
        .way_fill        (way_fill),
        .way_validate    (way_validate),
        .wb_full         (wb_full),
        .wb_empty        (wb_empty),
        .wb_enqueue      (wb_enqueue),
        .victim_way      (victim_way)
    );

    // Ways share the request and fill buses and differ only in strobes
    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        dcache_way i_dcache_way (
            .clock        (clock),
            .reset        (reset),
            .index        (index),
            .offset       (offset),
            .tag          (tag),
            .write_data   (write_data_q),
            .write_en     (write_en_q),
            .write_strobe (way_write[w]),
            .fill_data    (fill_data),
            .fill_offset  (fill_offset),
            .fill_strobe  (way_fill[w]),
            .validate     (way_validate[w]),
            .hit          (way_hit[w]),
            .valid        (way_valid[w]),
            .dirty        (way_dirty[w]),
            .word_out     (way_word[w]),
            .victim_tag   (way_tag[w]),
            .line_out     (way_line[w])
        );
    end

    dcache_write_buffer i_dcache_write_buffer (
        .clock              (clock),
        .reset              (reset),
        .enqueue            (wb_enqueue),
        .victim_way         (victim_way),
        .victim_index       (index),
        .way_tag            (way_tag),
        .way_line           (way_line),
        .fill_address       (fill_address),
        .mem_ready          (mem_ready),
        .full               (wb_full),
        .empty              (wb_empty),
        .mem_address        (mem_address),
        .mem_line_out       (mem_line_out),
        .mem_line_out_valid (mem_line_out_valid)
    );

endmodule

// ==== src/dcache_way.sv ====
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_way (
    input  logic                 clock,
    input  logic                 reset,
    input  dcache_pkg::index_t   index,
    input  dcache_pkg::offset_t  offset,
    input  dcache_pkg::tag_t     tag,
    input  dcache_pkg::word_t    write_data,
    input  dcache_pkg::byte_en_t write_en,
    input  logic                 write_strobe,
    input  dcache_pkg::word_t    fill_data,
    input  dcache_pkg::offset_t  fill_offset,
    input  logic                 fill_strobe,
    input  logic                 validate,
    output logic                 hit,
    output logic                 valid,
    output logic                 dirty,
    output dcache_pkg::word_t    word_out,
    output dcache_pkg::tag_t     victim_tag,
    output dcache_pkg::line_t    line_out
);

    import dcache_pkg::*;

    localparam int SETS  = 1 << `DCACHE_INDEX_BITS;
    localparam int WORDS = 1 << `DCACHE_OFFSET_BITS;

    tag_t            tag_mem [SETS];
    word_t           data_mem [SETS][WORDS];
    logic [SETS-1:0] valid_bits;
    logic [SETS-1:0] dirty_bits;

    // Data and tag arrays
    always_ff @(posedge clock) begin
        if (write_strobe) begin
            for (int b = 0; b < 4; b++) begin
                if (write_en[b]) begin
                    data_mem[index][offset][8*b +: 8] <= write_data[8*b +: 8];
                end
            end
        end
        if (fill_strobe) begin
            data_mem[index][fill_offset] <= fill_data; // One word per memory beat
        end
        if (validate) begin
            tag_mem[index] <= tag;
        end
    end

    // Line state bits
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (validate) begin
                valid_bits[index] <= 1'b1;
                dirty_bits[index] <= 1'b0; // Freshly filled line matches memory
            end
            if (write_strobe) begin
                dirty_bits[index] <= 1'b1;
            end
        end
    end

    // Lookup at the registered index
    assign valid      = valid_bits[index];
    assign dirty      = dirty_bits[index];
    assign victim_tag = tag_mem[index];
    assign hit        = valid & (tag_mem[index] == tag);
    assign word_out   = data_mem[index][offset];

    // Whole line for the write buffer
    always_comb begin
        line_out = '0;
        for (int w = 0; w < WORDS; w++) begin
            line_out[32*w +: 32] = data_mem[index][w];
        end
    end

endmodule

// ==== src/dcache_write_buffer.sv ====
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_write_buffer (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   enqueue,
    input  logic                   victim_way,
    input  dcache_pkg::index_t     victim_index,
    input  dcache_pkg::tag_t       way_tag [`DCACHE_WAYS],
    input  dcache_pkg::line_t      way_line [`DCACHE_WAYS],
    input  dcache_pkg::line_addr_t fill_address,
    input  logic                   mem_ready,
    output logic                   full,
    output logic                   empty,
    output dcache_pkg::line_addr_t mem_address,
    output dcache_pkg::line_t      mem_line_out,
    output logic                   mem_line_out_valid
);

    import dcache_pkg::*;

    localparam int DEPTH    = `DCACHE_WB_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);

    line_addr_t          addr_mem [DEPTH];
    line_t               line_mem [DEPTH];
    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic [PTR_BITS:0]   count;
    logic                do_enq;
    logic                do_deq;

    assign full   = (count == DEPTH[PTR_BITS:0]);
    assign empty  = (count == '0);
    assign do_enq = enqueue & ~full;
    assign do_deq = mem_ready & ~empty; // Memory took the head line

    always_ff @(posedge clock) begin
        if (do_enq) begin
            addr_mem[tail] <= {way_tag[victim_way], victim_index};
            line_mem[tail] <= way_line[victim_way];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_enq) begin
                tail <= tail + 1'b1;
            end
            if (do_deq) begin
                head <= head + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry owns the address bus until drained
    assign mem_address        = empty ? fill_address : addr_mem[head];
    assign mem_line_out       = line_mem[head];
    assign mem_line_out_valid = ~empty;

endmodule

// ==== verification/dcache_tb.sv ====
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tb;

    import dcache_pkg::*;

    localparam int KIND_ANY   = 0; // No latency or traffic expectation
    localparam int KIND_HIT   = 1;
    localparam int KIND_MISS  = 2;
    localparam int KIND_EVICT = 3; // Miss that must write back evict_line
    localparam int FIXED_OPS  = 14;
    localparam int RANDOM_OPS = 200;
    localparam int WATCHDOG_CYCLES = (FIXED_OPS + RANDOM_OPS) * 40 + 10;

    logic clock;
    logic reset;
    logic [`DCACHE_ADDR_BITS-1:0] address;
    logic read;
    byte_en_t write_en;
    word_t write_data;
    word_t read_data;
    logic ready;
    line_addr_t mem_address;
    logic mem_read_line;
    word_t mem_read_data;
    offset_t mem_read_offset;
    logic mem_ready;
    line_t mem_line_out;
    logic mem_line_out_valid;

    word_t mem_model [logic [`DCACHE_ADDR_BITS-1:0]];
    word_t shadow [logic [`DCACHE_ADDR_BITS-1:0]];
    integer seed;
    int errors = 0;
    int errors_at_start = 0;
    int passed = 0;
    int failed = 0;
    int expect_kind = KIND_ANY;
    int req_seq = 0;
    int seen_seq = 0;
    int cycles = 0;
    int fills = 0;
    int drains = 0;
    logic reset_settled = 1'b0;
    word_t expected_data;
    line_t expected_line;
    line_addr_t evict_line;

    dcache_top i_dcache_top (
        .clock              (clock),
        .reset              (reset),
        .address            (address),
        .read               (read),
        .write_en           (write_en),
        .write_data         (write_data),
        .read_data          (read_data),
        .ready              (ready),
        .mem_address        (mem_address),
        .mem_read_line      (mem_read_line),
        .mem_read_data      (mem_read_data),
        .mem_read_offset    (mem_read_offset),
        .mem_ready          (mem_ready),
        .mem_line_out       (mem_line_out),
        .mem_line_out_valid (mem_line_out_valid)
    );

    // Backing store pattern for words never written
    function automatic word_t init_word(input logic [`DCACHE_ADDR_BITS-1:0] a);
        return {a, 2'b11} ^ 32'h9e37_79b9;
    endfunction

    function automatic word_t shadow_word(input logic [`DCACHE_ADDR_BITS-1:0] a);
        return shadow.exists(a) ? shadow[a] : init_word(a);
    endfunction

    function automatic word_t memory_word(input logic [`DCACHE_ADDR_BITS-1:0] a);
        return mem_model.exists(a) ? mem_model[a] : init_word(a);
    endfunction

    function automatic line_t shadow_line(input line_addr_t la);
        line_t l;
        for (int w = 0; w < 4; w++) begin
            l[32*w +: 32] = shadow_word({la, offset_t'(w)});
        end
        return l;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data,
                                          input byte_en_t be);
        word_t m;
        m = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) m[8*b +: 8] = data[8*b +: 8];
        end
        return m;
    endfunction

    function automatic logic [`DCACHE_ADDR_BITS-1:0] make_addr(input tag_t t, input index_t i,
                                                              input offset_t o);
        return {t, i, o};
    endfunction

    initial begin : clock_gen
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Per-request latency and memory traffic
    always @(posedge clock) begin
        if (req_seq != seen_seq) begin
            seen_seq <= req_seq;
            cycles   <= 1;
            fills    <= 0;
            drains   <= 0;
        end else begin
            cycles <= cycles + 1;
            if (mem_read_line) fills <= fills + 1;
            if (mem_ready && mem_line_out_valid) drains <= drains + 1;
        end
    end

    assert property (@(posedge clock) (reset && reset_settled) |->
                     (!ready && !mem_read_line && !mem_line_out_valid))
        else begin
            errors = errors + 1;
            $display("** Error at %0t: ready or memory strobes high during reset", $time);
        end

    // Ready checks sample mid-cycle, while the request is still presented
    assert property (@(negedge clock) disable iff (reset) (ready && read) |->
                     (read_data == expected_data))
        else begin
            errors = errors + 1;
            $display("** Error at %0t: read data %h, expected %h", $time,
                     $sampled(read_data), $sampled(expected_data));
        end

    assert property (@(posedge clock) disable iff (reset) mem_read_line |->
                     (mem_address == address[`DCACHE_ADDR_BITS-1:`DCACHE_OFFSET_BITS]))
        else begin
            errors = errors + 1;
            $display("** Error at %0t: fill address %h for request %h", $time,
                     $sampled(mem_address), $sampled(address));
        end

    assert property (@(negedge clock) disable iff (reset)
                     (ready && expect_kind == KIND_HIT) |-> (cycles == 1 && fills == 0))
        else begin
            errors = errors + 1;
            $display("** Error at %0t: hit took %0d cycles with %0d fills", $time,
                     $sampled(cycles), $sampled(fills));
        end

    assert property (@(negedge clock) disable iff (reset)
                     (ready && expect_kind >= KIND_MISS) |-> (fills == 1))
        else begin
            errors = errors + 1;
            $display("** Error at %0t: miss saw %0d fills", $time, $sampled(fills));
        end

    assert property (@(negedge clock) disable iff (reset)
                     (ready && expect_kind == KIND_EVICT) |-> (drains == 1))
        else begin
            errors = errors + 1;
            $display("** Error at %0t: eviction saw %0d line writes", $time, $sampled(drains));
        end

    assert property (@(posedge clock) disable iff (reset)
                     (mem_ready && mem_line_out_valid && expect_kind == KIND_EVICT) |->
                     (mem_address == evict_line))
        else begin
            errors = errors + 1;
            $display("** Error at %0t: victim address %h, expected %h", $time,
                     $sampled(mem_address), $sampled(evict_line));
        end

    assert property (@(posedge clock) disable iff (reset)
                     (mem_ready && mem_line_out_valid) |-> (mem_line_out == expected_line))
        else begin
            errors = errors + 1;
            $display("** Error at %0t: victim line %h, expected %h", $time,
                     $sampled(mem_line_out), $sampled(expected_line));
        end

    // Memory answers fills and drains the write buffer, never both at once
    initial begin : memory_model
        line_addr_t fill_line;
        int gap;
        mem_ready       = 1'b0;
        mem_read_data   = '0;
        mem_read_offset = '0;
        forever begin
            @(negedge clock);
            mem_ready = 1'b0;
            if (mem_line_out_valid) begin
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) @(negedge clock);
                expected_line = shadow_line(mem_address);
                for (int w = 0; w < 4; w++) begin
                    mem_model[{mem_address, offset_t'(w)}] = mem_line_out[32*w +: 32];
                end
                mem_ready = 1'b1; // Dequeues the head entry
            end else if (mem_read_line) begin
                fill_line = mem_address;
                for (int w = 0; w < 4; w++) begin
                    @(negedge clock);
                    mem_ready = 1'b0;
                    gap = $unsigned($random(seed)) % 3;
                    repeat (gap) @(negedge clock);
                    mem_read_offset = offset_t'(w);
                    mem_read_data   = memory_word({fill_line, offset_t'(w)});
                    mem_ready       = 1'b1;
                end
            end
        end
    end

    // Presents one request on a falling edge and drops it in the ready cycle
    task automatic access(input logic [`DCACHE_ADDR_BITS-1:0] addr, input byte_en_t be,
                          input word_t data, input int kind);
        expect_kind   = kind;
        expected_data = shadow_word(addr);
        address       = addr;
        read          = (be == 4'b0000);
        write_en      = be;
        write_data    = data;
        req_seq       = req_seq + 1;
        do begin
            @(negedge clock);
        end while (!ready);
        if (be != 4'b0000) begin
            shadow[addr] = merge_bytes(shadow_word(addr), data, be);
        end
        read     = 1'b0;
        write_en = 4'b0000;
        @(negedge clock); // Controller is back in IDLE before the next request
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            passed = passed + 1;
            $display("test %s: ok", name);
        end else begin
            failed = failed + 1;
            $display("test %s: %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin : watchdog
        #(WATCHDOG_CYCLES * 4);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r;
        byte_en_t be;
        seed       = 32'hb9538744;
        reset      = 1'b1;
        address    = '0;
        read       = 1'b0;
        write_en   = 4'b0000;
        write_data = '0;
        evict_line = '0;
        repeat (2) @(posedge clock);
        reset_settled = 1'b1;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        access(make_addr(tag_t'(1), index_t'(5), offset_t'(2)), 4'b0000, '0, KIND_MISS);
        end_test("reset_and_first_read");
        access(make_addr(tag_t'(1), index_t'(5), offset_t'(3)), 4'b0000, '0, KIND_HIT);
        end_test("hit_latency");
        access(make_addr(tag_t'(1), index_t'(5), offset_t'(1)), 4'b0101, 32'hdead_beef,
               KIND_HIT);
        access(make_addr(tag_t'(1), index_t'(5), offset_t'(1)), 4'b0000, '0, KIND_HIT);
        end_test("byte_write");

        // A and B fill the set, C must replace B
        access(make_addr(tag_t'(2), index_t'(9), offset_t'(0)), 4'b0000, '0, KIND_MISS);
        access(make_addr(tag_t'(3), index_t'(9), offset_t'(0)), 4'b0000, '0, KIND_MISS);
        access(make_addr(tag_t'(2), index_t'(9), offset_t'(1)), 4'b0000, '0, KIND_HIT);
        access(make_addr(tag_t'(4), index_t'(9), offset_t'(2)), 4'b0000, '0, KIND_MISS);
        access(make_addr(tag_t'(2), index_t'(9), offset_t'(3)), 4'b0000, '0, KIND_HIT);
        access(make_addr(tag_t'(3), index_t'(9), offset_t'(0)), 4'b0000, '0, KIND_MISS);
        end_test("lru_replacement");

        evict_line = {tag_t'(5), index_t'(12)};
        access(make_addr(tag_t'(5), index_t'(12), offset_t'(2)), 4'b1111, 32'h1234_5678,
               KIND_MISS);
        access(make_addr(tag_t'(6), index_t'(12), offset_t'(0)), 4'b0000, '0, KIND_MISS);
        access(make_addr(tag_t'(7), index_t'(12), offset_t'(1)), 4'b0000, '0, KIND_EVICT);
        access(make_addr(tag_t'(5), index_t'(12), offset_t'(2)), 4'b0000, '0, KIND_MISS);
        end_test("dirty_eviction");

        for (int i = 0; i < RANDOM_OPS; i++) begin
            r = $random(seed);
            if (r[6]) begin
                be = (r[10:7] == 4'b0000) ? 4'b1111 : r[10:7];
            end else begin
                be = 4'b0000;
            end
            access(make_addr(tag_t'(8 + r[1:0]), index_t'(20 + r[3:2]), r[5:4]), be,
                   $random(seed), KIND_ANY);
        end
        end_test("random_mix");

        $display("Summary: %0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
